//--- files.f
+incdir+include
logic/mipsPkg.sv
logic/atDecoder.sv
logic/stageTracker.sv
logic/stallControl.sv
logic/forwardSelect.sv
logic/mduBusyTimer.sv
logic/hazardUnit.sv
tests/hazardUnitTb.sv

//--- include/hazard_params.svh
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// Width of a register number where zero means none
`define HAZARD_REG_W 5

// Width of a Tuse or Tnew count
`define HAZARD_T_W 2

// Busy cycles of the multiply/divide unit after an operation starts
`define HAZARD_MULT_CYCLES 5
`define HAZARD_DIV_CYCLES 10

// Only the longer latency sizes the busy counter
`define HAZARD_MDU_MAX \
	((`HAZARD_DIV_CYCLES > `HAZARD_MULT_CYCLES) ? `HAZARD_DIV_CYCLES : `HAZARD_MULT_CYCLES)

`endif

//--- logic/atDecoder.sv
`timescale 1ns/10ps
`include "hazard_params.svh"

module atDecoder
(
	input  logic [31:0]               instr,
	output logic [`HAZARD_REG_W-1:0]  a1,
	output logic [`HAZARD_REG_W-1:0]  a2,
	output logic [`HAZARD_REG_W-1:0]  a3,
	output logic [`HAZARD_T_W-1:0]    tuse1,
	output logic [`HAZARD_T_W-1:0]    tuse2,
	output logic [`HAZARD_T_W-1:0]    tnew,
	output mipsPkg::mduKindT          mduKind
);

	localparam logic [`HAZARD_REG_W-1:0] r0 = 'd0;
	localparam logic [`HAZARD_REG_W-1:0] ra = 'd31;
	localparam logic [`HAZARD_T_W-1:0] t0 = 'd0;
	localparam logic [`HAZARD_T_W-1:0] t1 = 'd1;
	localparam logic [`HAZARD_T_W-1:0] t2 = 'd2;
	localparam logic [`HAZARD_T_W-1:0] t3 = 'd3;

	mipsPkg::opcodeT opcode;
	mipsPkg::functT funct;
	mipsPkg::regimmT regimmRt;
	logic [`HAZARD_REG_W-1:0] rs;
	logic [`HAZARD_REG_W-1:0] rt;
	logic [`HAZARD_REG_W-1:0] rd;

	assign opcode = mipsPkg::opcodeT'(instr[31:26]);
	assign funct = mipsPkg::functT'(instr[5:0]);
	assign regimmRt = mipsPkg::regimmT'(instr[20:16]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	// Fields are {a1, tuse1, a2, tuse2, a3, tnew}
	// Unknown encodings keep the all-zero default
	always_comb
	begin
		{a1, tuse1, a2, tuse2, a3, tnew} = {r0, t0, r0, t0, r0, t0};
		mduKind = mipsPkg::mduNone;
		case (opcode)
			mipsPkg::opSpecial:
			begin
				case (funct)
					mipsPkg::fnAdd, mipsPkg::fnAddu, mipsPkg::fnSub, mipsPkg::fnSubu,
					mipsPkg::fnAnd, mipsPkg::fnOr, mipsPkg::fnXor, mipsPkg::fnNor,
					mipsPkg::fnSllv, mipsPkg::fnSrlv, mipsPkg::fnSrav,
					mipsPkg::fnSlt, mipsPkg::fnSltu:
						{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t1, rt, t1, rd, t2};
					// Constant shifts ignore rs
					mipsPkg::fnSll, mipsPkg::fnSrl, mipsPkg::fnSra:
						{a1, tuse1, a2, tuse2, a3, tnew} = {r0, t0, rt, t1, rd, t2};
					mipsPkg::fnMult, mipsPkg::fnMultu:
					begin
						{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t1, rt, t1, r0, t0};
						mduKind = mipsPkg::mduMult;
					end
					mipsPkg::fnDiv, mipsPkg::fnDivu:
					begin
						{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t1, rt, t1, r0, t0};
						mduKind = mipsPkg::mduDiv;
					end
					mipsPkg::fnMfhi, mipsPkg::fnMflo:
					begin
						{a1, tuse1, a2, tuse2, a3, tnew} = {r0, t0, r0, t0, rd, t2};
						mduKind = mipsPkg::mduMove;
					end
					mipsPkg::fnMthi, mipsPkg::fnMtlo:
					begin
						{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t1, r0, t0, r0, t0};
						mduKind = mipsPkg::mduMove;
					end
					// Jump target is needed in D
					mipsPkg::fnJr:
						{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t0, r0, t0, r0, t0};
					mipsPkg::fnJalr:
						{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t0, r0, t0, rd, t1};
				endcase
			end
			mipsPkg::opAddi, mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu,
			mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori:
				{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t1, r0, t0, rt, t2};
			mipsPkg::opLui:
				{a1, tuse1, a2, tuse2, a3, tnew} = {r0, t0, r0, t0, rt, t2};
			// Loaded data exists after M
			mipsPkg::opLb, mipsPkg::opLh, mipsPkg::opLw, mipsPkg::opLbu, mipsPkg::opLhu:
				{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t1, r0, t0, rt, t3};
			// Store data is not needed until M
			mipsPkg::opSb, mipsPkg::opSh, mipsPkg::opSw:
				{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t1, rt, t2, r0, t0};
			mipsPkg::opBeq, mipsPkg::opBne:
				{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t0, rt, t0, r0, t0};
			mipsPkg::opBlez, mipsPkg::opBgtz:
				{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t0, r0, t0, r0, t0};
			mipsPkg::opRegimm:
			begin
				if (regimmRt == mipsPkg::rtBltz || regimmRt == mipsPkg::rtBgez)
					{a1, tuse1, a2, tuse2, a3, tnew} = {rs, t0, r0, t0, r0, t0};
			end
			// Plain J touches no register
			mipsPkg::opJ:
				{a1, tuse1, a2, tuse2, a3, tnew} = {r0, t0, r0, t0, r0, t0};
			mipsPkg::opJal:
				{a1, tuse1, a2, tuse2, a3, tnew} = {r0, t0, r0, t0, ra, t1};
		endcase
	end

endmodule

//--- logic/forwardSelect.sv
`timescale 1ns/10ps
`include "hazard_params.svh"

module forwardSelect
(
	input  logic [`HAZARD_REG_W-1:0]  a1D,
	input  logic [`HAZARD_REG_W-1:0]  a2D,
	input  logic [`HAZARD_REG_W-1:0]  a1E,
	input  logic [`HAZARD_REG_W-1:0]  a2E,
	input  logic [`HAZARD_REG_W-1:0]  a2M,
	input  logic [`HAZARD_REG_W-1:0]  a3E,
	input  logic [`HAZARD_T_W-1:0]    tnewE,
	input  logic [`HAZARD_REG_W-1:0]  a3M,
	input  logic [`HAZARD_T_W-1:0]    tnewM,
	input  logic [`HAZARD_REG_W-1:0]  a3W,
	input  logic [`HAZARD_T_W-1:0]    tnewW,
	output mipsPkg::forwardSelT       fwdRsD,
	output mipsPkg::forwardSelT       fwdRtD,
	output mipsPkg::forwardSelT       fwdRsE,
	output mipsPkg::forwardSelT       fwdRtE,
	output mipsPkg::forwardSelT       fwdRtM
);

	// Nearest finished producer wins, W is always a candidate
	function automatic mipsPkg::forwardSelT nearest
	(
		input logic [`HAZARD_REG_W-1:0] src,
		input logic                     fromE,
		input logic                     fromM
	);
		if (src == '0)
			return mipsPkg::fwdNone;
		if (fromE && src == a3E && tnewE == '0)
			return mipsPkg::fwdE;
		if (fromM && src == a3M && tnewM == '0)
			return mipsPkg::fwdM;
		if (src == a3W && tnewW == '0)
			return mipsPkg::fwdW;
		return mipsPkg::fwdNone;
	endfunction

	always_comb
	begin
		// Read in D
		fwdRsD = nearest(a1D, 1'b1, 1'b1);
		fwdRtD = nearest(a2D, 1'b1, 1'b1);
		// Read in E
		fwdRsE = nearest(a1E, 1'b0, 1'b1);
		fwdRtE = nearest(a2E, 1'b0, 1'b1);
		// store data in M
		fwdRtM = nearest(a2M, 1'b0, 1'b0);
	end

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/10ps
`include "hazard_params.svh"

module hazardUnit
(
	input  logic                 clk,
	input  logic                 rstN,
	input  logic [31:0]          instrD,
	output logic                 stall,
	output logic                 mduBusy,
	output mipsPkg::forwardSelT  fwdRsD,
	output mipsPkg::forwardSelT  fwdRtD,
	output mipsPkg::forwardSelT  fwdRsE,
	output mipsPkg::forwardSelT  fwdRtE,
	output mipsPkg::forwardSelT  fwdRtM
);

	// Decode stage facts
	logic [`HAZARD_REG_W-1:0] a1D, a2D, a3D;
	logic [`HAZARD_T_W-1:0] tuse1D, tuse2D, tnewD;
	mipsPkg::mduKindT mduKindD;

	// Tracked stage facts
	logic [`HAZARD_REG_W-1:0] a1E, a2E, a3E, a2M, a3M, a3W;
	logic [`HAZARD_T_W-1:0] tnewE, tnewM, tnewW;
	mipsPkg::mduKindT mduKindE;

	atDecoder iDecoder (.instr(instrD), .a1(a1D), .a2(a2D), .a3(a3D),
		.tuse1(tuse1D), .tuse2(tuse2D), .tnew(tnewD), .mduKind(mduKindD));

	stageTracker iTracker (.clk(clk), .rstN(rstN), .stall(stall),
		.a1D(a1D), .a2D(a2D), .a3D(a3D), .tnewD(tnewD), .mduKindD(mduKindD),
		.a1E(a1E), .a2E(a2E), .a3E(a3E), .tnewE(tnewE), .mduKindE(mduKindE),
		.a2M(a2M), .a3M(a3M), .tnewM(tnewM), .a3W(a3W), .tnewW(tnewW));

	stallControl iStall (.a1D(a1D), .tuse1D(tuse1D), .a2D(a2D), .tuse2D(tuse2D),
		.mduKindD(mduKindD), .a3E(a3E), .tnewE(tnewE), .a3M(a3M), .tnewM(tnewM),
		.mduKindE(mduKindE), .mduBusy(mduBusy), .stall(stall));

	forwardSelect iForward (.a1D(a1D), .a2D(a2D), .a1E(a1E), .a2E(a2E), .a2M(a2M),
		.a3E(a3E), .tnewE(tnewE), .a3M(a3M), .tnewM(tnewM), .a3W(a3W), .tnewW(tnewW),
		.fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .fwdRsE(fwdRsE), .fwdRtE(fwdRtE),
		.fwdRtM(fwdRtM));

	mduBusyTimer iTimer (.clk(clk), .rstN(rstN), .mduKindE(mduKindE), .mduBusy(mduBusy));

endmodule

//--- logic/mduBusyTimer.sv
`timescale 1ns/10ps
`include "hazard_params.svh"

module mduBusyTimer
(
	input  logic              clk,
	input  logic              rstN,
	input  mipsPkg::mduKindT  mduKindE,
	output logic              mduBusy
);

	localparam int cntW = $clog2(`HAZARD_MDU_MAX + 1);
	localparam logic [cntW-1:0] multLoad = cntW'(`HAZARD_MULT_CYCLES);
	localparam logic [cntW-1:0] divLoad = cntW'(`HAZARD_DIV_CYCLES);

	logic [cntW-1:0] count;

	// Loads on the edge after the operation sits in E
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			count <= '0;
		else if (mduKindE == mipsPkg::mduMult)
			count <= multLoad;
		else if (mduKindE == mipsPkg::mduDiv)
			count <= divLoad;
		else if (count != '0)
			count <= count - 1'b1;
	end

	// One busy cycle per remaining count
	assign mduBusy = (count != '0);

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////////////////////////

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0]
	{
		opSpecial = 6'h00,
		opRegimm  = 6'h01,
		opJ       = 6'h02,
		opJal     = 6'h03,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opBlez    = 6'h06,
		opBgtz    = 6'h07,
		opAddi    = 6'h08,
		opAddiu   = 6'h09,
		opSlti    = 6'h0a,
		opSltiu   = 6'h0b,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opXori    = 6'h0e,
		opLui     = 6'h0f,
		opLb      = 6'h20,
		opLh      = 6'h21,
		opLw      = 6'h23,
		opLbu     = 6'h24,
		opLhu     = 6'h25,
		opSb      = 6'h28,
		opSh      = 6'h29,
		opSw      = 6'h2b
	} opcodeT;

	// SPECIAL function field, instr[5:0]
	typedef enum logic [5:0]
	{
		fnSll = 6'h00, fnSrl = 6'h02, fnSra = 6'h03,
		fnSllv = 6'h04, fnSrlv = 6'h06, fnSrav = 6'h07,
		fnJr = 6'h08, fnJalr = 6'h09,
		fnMfhi = 6'h10, fnMthi = 6'h11, fnMflo = 6'h12, fnMtlo = 6'h13,
		fnMult = 6'h18, fnMultu = 6'h19, fnDiv = 6'h1a, fnDivu = 6'h1b,
		fnAdd = 6'h20, fnAddu = 6'h21, fnSub = 6'h22, fnSubu = 6'h23,
		fnAnd = 6'h24, fnOr = 6'h25, fnXor = 6'h26, fnNor = 6'h27,
		fnSlt = 6'h2a, fnSltu = 6'h2b
	} functT;

	// REGIMM rt field, instr[20:16]
	typedef enum logic [4:0]
	{
		rtBltz = 5'h00,
		rtBgez = 5'h01
	} regimmT;

	//////////////////////////////////////////////////////////////////////
	// Hazard control types
	//////////////////////////////////////////////////////////////////////

	// How an instruction uses the multiply/divide unit
	typedef enum logic [1:0]
	{
		mduNone,
		mduMult,
		mduDiv,
		mduMove
	} mduKindT;

	// Stage that supplies a forwarded operand
	typedef enum logic [1:0]
	{
		fwdNone,
		fwdE,
		fwdM,
		fwdW
	} forwardSelT;

endpackage

//--- logic/stageTracker.sv
`timescale 1ns/10ps
`include "hazard_params.svh"

module stageTracker
(
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      stall,
	input  logic [`HAZARD_REG_W-1:0]  a1D,
	input  logic [`HAZARD_REG_W-1:0]  a2D,
	input  logic [`HAZARD_REG_W-1:0]  a3D,
	input  logic [`HAZARD_T_W-1:0]    tnewD,
	input  mipsPkg::mduKindT          mduKindD,
	output logic [`HAZARD_REG_W-1:0]  a1E,
	output logic [`HAZARD_REG_W-1:0]  a2E,
	output logic [`HAZARD_REG_W-1:0]  a3E,
	output logic [`HAZARD_T_W-1:0]    tnewE,
	output mipsPkg::mduKindT          mduKindE,
	output logic [`HAZARD_REG_W-1:0]  a2M,
	output logic [`HAZARD_REG_W-1:0]  a3M,
	output logic [`HAZARD_T_W-1:0]    tnewM,
	output logic [`HAZARD_REG_W-1:0]  a3W,
	output logic [`HAZARD_T_W-1:0]    tnewW
);

	// Remaining cycles shrink by one per stage and stop at zero
	function automatic logic [`HAZARD_T_W-1:0] countDown(input logic [`HAZARD_T_W-1:0] t);
		return (t == '0) ? '0 : t - 1'b1;
	endfunction

	// D to E loads a bubble while D is held
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			a1E <= '0;
			a2E <= '0;
			a3E <= '0;
			tnewE <= '0;
			mduKindE <= mipsPkg::mduNone;
		end
		else if (stall)
		begin
			a1E <= '0;
			a2E <= '0;
			a3E <= '0;
			tnewE <= '0;
			mduKindE <= mipsPkg::mduNone;
		end
		else
		begin
			a1E <= a1D;
			a2E <= a2D;
			a3E <= a3D;
			tnewE <= countDown(tnewD);
			mduKindE <= mduKindD;
		end
	end

	// E to M and M to W drain every cycle
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			a2M <= '0;
			a3M <= '0;
			tnewM <= '0;
			a3W <= '0;
			tnewW <= '0;
		end
		else
		begin
			a2M <= a2E;
			a3M <= a3E;
			tnewM <= countDown(tnewE);
			a3W <= a3M;
			tnewW <= countDown(tnewM);
		end
	end

endmodule

//--- logic/stallControl.sv
`timescale 1ns/10ps
`include "hazard_params.svh"

module stallControl
(
	input  logic [`HAZARD_REG_W-1:0]  a1D,
	input  logic [`HAZARD_T_W-1:0]    tuse1D,
	input  logic [`HAZARD_REG_W-1:0]  a2D,
	input  logic [`HAZARD_T_W-1:0]    tuse2D,
	input  mipsPkg::mduKindT          mduKindD,
	input  logic [`HAZARD_REG_W-1:0]  a3E,
	input  logic [`HAZARD_T_W-1:0]    tnewE,
	input  logic [`HAZARD_REG_W-1:0]  a3M,
	input  logic [`HAZARD_T_W-1:0]    tnewM,
	input  mipsPkg::mduKindT          mduKindE,
	input  logic                      mduBusy,
	output logic                      stall
);

	logic regStall;
	logic mduStall;

	// Source still waits on a result in one later stage
	function automatic logic notReady
	(
		input logic [`HAZARD_REG_W-1:0] src,
		input logic [`HAZARD_T_W-1:0]   tuse,
		input logic [`HAZARD_REG_W-1:0] dst,
		input logic [`HAZARD_T_W-1:0]   tnewLeft
	);
		return (src != '0) && (src == dst) && (tnewLeft > tuse);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Tuse against remaining Tnew
	//////////////////////////////////////////////////////////////////////

	assign regStall = notReady(a1D, tuse1D, a3E, tnewE)
		| notReady(a1D, tuse1D, a3M, tnewM)
		| notReady(a2D, tuse2D, a3E, tnewE)
		| notReady(a2D, tuse2D, a3M, tnewM);

	//////////////////////////////////////////////////////////////////////
	// Multiply/divide exclusion
	//////////////////////////////////////////////////////////////////////

	// An operation in E has not yet loaded the busy counter
	assign mduStall = (mduKindD != mipsPkg::mduNone)
		&& (mduBusy || mduKindE == mipsPkg::mduMult || mduKindE == mipsPkg::mduDiv);

	assign stall = regStall | mduStall;

endmodule

//--- tests/hazardUnitTb.sv
`timescale 1ns/10ps
`include "hazard_params.svh"

module hazardUnitTb;

	localparam int nRandom = 200;
	// Each issue waits at most one divide plus a bubble
	localparam int watchdogNs = (nRandom + 40) * (`HAZARD_DIV_CYCLES + 2) * 8 + 100;
	// SPECIAL, SPECIAL, LW, SW, BEQ, ADDIU, JAL, REGIMM
	localparam logic [47:0] opTable = {6'h00, 6'h00, 6'h23, 6'h2b, 6'h04, 6'h09, 6'h03, 6'h01};
	// ADDU, SUBU, MULT, DIV, MFLO, MTHI, JR, JALR
	localparam logic [47:0] fnTable = {6'h21, 6'h23, 6'h18, 6'h1a, 6'h12, 6'h11, 6'h08, 6'h09};

	logic clk;
	logic rstN;
	logic [31:0] instrD;
	logic stall;
	logic mduBusy;
	mipsPkg::forwardSelT fwdRsD, fwdRtD, fwdRsE, fwdRtE, fwdRtM;

	// Shadow of the E, M and W stages
	logic [4:0] eA1, eA2, eA3, mA2, mA3, wA3;
	logic [1:0] eT, eK, mT, wT;
	int busyLeft;
	int busyCycles;
	int nStall;
	logic [1:0] lastRsD, lastRsE, lastRtM;
	logic [31:0] lcgState;

	hazardUnit i_dut (.clk(clk), .rstN(rstN), .instrD(instrD), .stall(stall), .mduBusy(mduBusy),
		.fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .fwdRsE(fwdRsE), .fwdRtE(fwdRtE), .fwdRtM(fwdRtM));

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		#(watchdogNs);
		$display("Timeout after %0d ns, the tests did not finish", watchdogNs);
		$display("Testbench failed");
		$fatal(1);
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			$display("ERR time=%0t %s got=%0h expected=%0h", $time, name, got, want);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [31:0] rOp(input logic [5:0] fn, input logic [4:0] rs, rt, rd);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iOp(input logic [5:0] op, input logic [4:0] rs, rt);
		return {op, rs, rt, 16'h0010};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Packed as {a1, tuse1, a2, tuse2, a3, tnew, mduKind}
	function automatic logic [22:0] refDecode(input logic [31:0] w);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		op = w[31:26];
		fn = w[5:0];
		rs = w[25:21];
		rt = w[20:16];
		rd = w[15:11];
		refDecode = '0;
		if (op == 6'h00)
		begin
			if (fn[5:3] == 3'b100 || fn[5:1] == 5'b10101 || fn == 6'h04 || fn[5:1] == 5'b00011)
				refDecode = {rs, 2'd1, rt, 2'd1, rd, 2'd2, mipsPkg::mduNone};
			else if (fn == 6'h00 || fn[5:1] == 5'b00001)
				refDecode = {7'd0, rt, 2'd1, rd, 2'd2, mipsPkg::mduNone};
			else if (fn[5:2] == 4'b0110)
				refDecode = {rs, 2'd1, rt, 2'd1, 7'd0, fn[1] ? mipsPkg::mduDiv : mipsPkg::mduMult};
			else if (fn[5:2] == 4'b0100)
				refDecode = fn[0] ? {rs, 2'd1, 14'd0, mipsPkg::mduMove}
					: {14'd0, rd, 2'd2, mipsPkg::mduMove};
			else if (fn[5:1] == 5'b00100)
				refDecode = {rs, 9'd0, fn[0] ? {rd, 2'd1} : 7'd0, mipsPkg::mduNone};
		end
		else if ((op == 6'h01 && rt[4:1] == 4'd0) || op[5:1] == 5'b00011)
			refDecode = {rs, 18'd0};
		else if (op[5:1] == 5'b00010)
			refDecode = {rs, 2'd0, rt, 11'd0};
		else if (op == 6'h03)
			refDecode = {14'd0, 5'd31, 2'd1, mipsPkg::mduNone};
		else if (op == 6'h0f)
			refDecode = {14'd0, rt, 2'd2, mipsPkg::mduNone};
		else if (op[5:3] == 3'b001)
			refDecode = {rs, 2'd1, 7'd0, rt, 2'd2, mipsPkg::mduNone};
		else if (op == 6'h20 || op == 6'h21 || op == 6'h23 || op == 6'h24 || op == 6'h25)
			refDecode = {rs, 2'd1, 7'd0, rt, 2'd3, mipsPkg::mduNone};
		else if (op == 6'h28 || op == 6'h29 || op == 6'h2b)
			refDecode = {rs, 2'd1, rt, 2'd2, 9'd0};
	endfunction

	function automatic logic [1:0] oneLess(input logic [1:0] t);
		return (t == 2'd0) ? 2'd0 : t - 2'd1;
	endfunction

	function automatic logic waits(input logic [4:0] src, dst, input logic [1:0] tuse, tLeft);
		return src != 5'd0 && src == dst && tLeft > tuse;
	endfunction

	function automatic logic [1:0] refFwd(input logic [4:0] src, input logic inE, inM);
		if (src == 5'd0)
			return mipsPkg::fwdNone;
		else if (inE && src == eA3 && eT == 2'd0)
			return mipsPkg::fwdE;
		else if (inM && src == mA3 && mT == 2'd0)
			return mipsPkg::fwdM;
		else if (src == wA3 && wT == 2'd0)
			return mipsPkg::fwdW;
		return mipsPkg::fwdNone;
	endfunction

	// Sampled mid-cycle, where every output is settled
	task automatic checkCycle(output logic s);
		logic [22:0] d;
		d = refDecode(instrD);
		s = waits(d[22:18], eA3, d[17:16], eT) | waits(d[22:18], mA3, d[17:16], mT)
			| waits(d[15:11], eA3, d[10:9], eT) | waits(d[15:11], mA3, d[10:9], mT);
		if (d[1:0] != mipsPkg::mduNone
			&& (busyLeft != 0 || eK == mipsPkg::mduMult || eK == mipsPkg::mduDiv))
			s = 1'b1;
		compare("stall", stall, s);
		compare("mduBusy", mduBusy, busyLeft != 0);
		compare("fwdRsD", fwdRsD, refFwd(d[22:18], 1'b1, 1'b1));
		compare("fwdRtD", fwdRtD, refFwd(d[15:11], 1'b1, 1'b1));
		compare("fwdRsE", fwdRsE, refFwd(eA1, 1'b0, 1'b1));
		compare("fwdRtE", fwdRtE, refFwd(eA2, 1'b0, 1'b1));
		compare("fwdRtM", fwdRtM, refFwd(mA2, 1'b0, 1'b0));
		if (mduBusy)
			busyCycles++;
		lastRsD = fwdRsD;
		lastRsE = fwdRsE;
		lastRtM = fwdRtM;
	endtask

	task automatic advance(input logic [31:0] w, input logic s);
		logic [22:0] d;
		d = refDecode(w);
		{wA3, wT} = {mA3, oneLess(mT)};
		{mA2, mA3, mT} = {eA2, eA3, oneLess(eT)};
		if (eK == mipsPkg::mduMult)
			busyLeft = `HAZARD_MULT_CYCLES;
		else if (eK == mipsPkg::mduDiv)
			busyLeft = `HAZARD_DIV_CYCLES;
		else if (busyLeft != 0)
			busyLeft--;
		// A stalled issue leaves a bubble in E
		if (s)
			{eA1, eA2, eA3, eT, eK} = 19'd0;
		else
			{eA1, eA2, eA3, eT, eK} = {d[22:18], d[15:11], d[8:4], oneLess(d[3:2]), d[1:0]};
	endtask

	// Holds the word in D until it leaves, counting stalled cycles
	task automatic issue(input logic [31:0] w, output int stalls);
		logic s;
		stalls = 0;
		instrD <= w;
		do
		begin
			@(negedge clk);
			checkCycle(s);
			@(posedge clk);
			advance(w, s);
			if (s)
				stalls++;
		end while (s);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic testReset();
		issue(32'h0, nStall);
		compare("reset stall cycles", nStall, 0);
		compare("reset busy cycles", busyCycles, 0);
		compare("reset fwdRsD", lastRsD, mipsPkg::fwdNone);
		compare("reset fwdRsE", lastRsE, mipsPkg::fwdNone);
		compare("reset fwdRtM", lastRtM, mipsPkg::fwdNone);
	endtask

	task automatic testLoadUse();
		issue(iOp(mipsPkg::opLw, 5'd1, 5'd8), nStall);
		issue(rOp(mipsPkg::fnAddu, 5'd8, 5'd2, 5'd10), nStall);
		compare("load-use stall cycles", nStall, 1);
		issue(32'h0, nStall);
		compare("load-use fwdRsE", lastRsE, mipsPkg::fwdW);
	endtask

	task automatic testAluBranch();
		issue(rOp(mipsPkg::fnAddu, 5'd1, 5'd2, 5'd3), nStall);
		issue(iOp(mipsPkg::opBeq, 5'd3, 5'd0), nStall);
		compare("branch stall cycles", nStall, 1);
		compare("branch fwdRsD", lastRsD, mipsPkg::fwdM);
		issue(rOp(mipsPkg::fnAddu, 5'd1, 5'd2, 5'd5), nStall);
		issue(rOp(mipsPkg::fnAddu, 5'd5, 5'd0, 5'd6), nStall);
		compare("ALU chain stall cycles", nStall, 0);
		issue(32'h0, nStall);
		compare("ALU chain fwdRsE", lastRsE, mipsPkg::fwdM);
	endtask

	task automatic testLinkAndStore();
		issue({6'h03, 26'h40}, nStall);
		issue(rOp(mipsPkg::fnJr, 5'd31, 5'd0, 5'd0), nStall);
		compare("JR stall cycles", nStall, 0);
		compare("JR fwdRsD", lastRsD, mipsPkg::fwdE);
		issue(rOp(mipsPkg::fnAddu, 5'd1, 5'd2, 5'd9), nStall);
		issue(iOp(mipsPkg::opSw, 5'd1, 5'd9), nStall);
		compare("store stall cycles", nStall, 0);
		issue(32'h0, nStall);
		issue(32'h0, nStall);
		compare("store fwdRtM", lastRtM, mipsPkg::fwdW);
	endtask

	task automatic testMdu();
		busyCycles = 0;
		issue(rOp(mipsPkg::fnMult, 5'd1, 5'd2, 5'd0), nStall);
		issue(rOp(mipsPkg::fnMflo, 5'd0, 5'd0, 5'd7), nStall);
		compare("MFLO stall cycles", nStall, `HAZARD_MULT_CYCLES + 1);
		compare("busy cycles after MULT", busyCycles, `HAZARD_MULT_CYCLES);
		issue(rOp(mipsPkg::fnDiv, 5'd3, 5'd4, 5'd0), nStall);
		issue(rOp(mipsPkg::fnMfhi, 5'd0, 5'd0, 5'd8), nStall);
		compare("MFHI stall cycles", nStall, `HAZARD_DIV_CYCLES + 1);
		issue(rOp(mipsPkg::fnMult, 5'd1, 5'd2, 5'd0), nStall);
		issue(rOp(mipsPkg::fnAddu, 5'd9, 5'd10, 5'd11), nStall);
		compare("ALU stall behind MULT", nStall, 0);
	endtask

	task automatic testZeroAndRandom();
		logic [31:0] r;
		logic [31:0] w;
		int i;
		issue(rOp(mipsPkg::fnAddu, 5'd1, 5'd2, 5'd0), nStall);
		issue(iOp(mipsPkg::opBeq, 5'd0, 5'd0), nStall);
		compare("r0 branch stall cycles", nStall, 0);
		compare("r0 branch fwdRsD", lastRsD, mipsPkg::fwdNone);
		issue(iOp(mipsPkg::opLw, 5'd1, 5'd0), nStall);
		issue(rOp(mipsPkg::fnAddu, 5'd0, 5'd0, 5'd3), nStall);
		compare("r0 load stall cycles", nStall, 0);
		for (i = 0; i < nRandom; i++)
		begin
			r = lcgNext();
			case (i % 4)
				0: w = r;
				// rt and rd cleared, so results go to r0
				1: w = r & 32'hffe0_07ff;
				2: w = {6'h3f, r[25:0]};
				// Known encodings on r0..r3 for dense dependencies
				default: w = {opTable[r[31:29] * 6 +: 6], 3'd0, r[22:21], 3'd0, r[17:16],
					3'd0, r[12:11], 5'd0, fnTable[r[8:6] * 6 +: 6]};
			endcase
			issue(w, nStall);
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		instrD = '0;
		lcgState = 32'h70d4_0444;
		{eA1, eA2, eA3, eT, eK} = 19'd0;
		{mA2, mA3, mT, wA3, wT} = 19'd0;
		busyLeft = 0;
		busyCycles = 0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		testReset();
		testLoadUse();
		testAluBranch();
		testLinkAndStore();
		testMdu();
		testZeroAndRandom();
		$display("Testbench passed");
		$finish;
	end

endmodule
